// File: rtl/cpuCtrlPkg.sv
// Shared definitions for the hardwired CPU control unit
// Opcode, ALU operation, instruction class and step encodings plus the control word
`default_nettype none

package cpuCtrlPkg;

    // Opcode field in the top five bits of the IR
    typedef enum logic [4:0] {
        OpLd   = 5'd0,
        OpLdi  = 5'd1,
        OpSt   = 5'd2,
        OpAdd  = 5'd3,
        OpSub  = 5'd4,
        OpAnd  = 5'd5,
        OpOr   = 5'd6,
        OpShr  = 5'd7,
        OpShra = 5'd8,
        OpShl  = 5'd9,
        OpRor  = 5'd10,
        OpRol  = 5'd11,
        OpAddi = 5'd12,
        OpAndi = 5'd13,
        OpOri  = 5'd14,
        OpNeg  = 5'd17,
        OpNot  = 5'd18,
        OpBr   = 5'd19,
        OpJr   = 5'd20,
        OpJal  = 5'd21,
        OpIn   = 5'd22,
        OpOut  = 5'd23
    } opcode_t;

    // Operation select seen by the datapath ALU
    typedef enum logic [4:0] {
        AluNop  = 5'd0,  AluAdd = 5'd1,  AluSub = 5'd2,
        AluShr  = 5'd5,  AluShl = 5'd6,  AluShra = 5'd7,
        AluRor  = 5'd8,  AluRol = 5'd9,  AluAnd = 5'd10,
        AluOr   = 5'd11, AluNeg = 5'd12, AluNot = 5'd15
    } aluOp_t;

    // Instructions that share one execute sequence
    typedef enum logic [3:0] {
        ClassAluReg,  ClassAluUnary, ClassAluImm, ClassLoadImm,
        ClassLoad,    ClassStore,    ClassBranch, ClassJumpReg,
        ClassJumpLink, ClassInPort,  ClassOutPort, ClassNop
    } instrClass_t;

    // Sequencer steps, fetch first and then up to five execute steps
    typedef enum logic [3:0] {
        StepStartup,
        StepFetch0, StepFetch1, StepFetch2, StepFetch3,
        StepExec0,  StepExec1,  StepExec2,  StepExec3, StepExec4
    } step_t;

    // Datapath enables, 25 bits
    typedef struct packed {
        logic   gra;
        logic   grb;
        logic   grc;
        logic   rIn;
        logic   rOut;
        logic   baOut;
        logic   cOut;
        logic   connIn;
        logic   marIn;
        logic   mdrIn;
        logic   mdrOut;
        logic   yIn;
        logic   zIn;
        logic   zLowOut;
        logic   pcIn;
        logic   pcOut;
        logic   incPc;
        logic   irIn;
        logic   inPortOut;
        logic   outPortIn;
        aluOp_t aluOp;
    } ctrlWord_t;

endpackage

`default_nettype wire

// File: rtl/opcodeDecoder.sv
// Opcode decoder
// Maps the IR opcode field to an instruction class and the ALU operation of exec1
`default_nettype none

module opcodeDecoder
    import cpuCtrlPkg::*;
#(
    parameter int IrWidth = 32
) (
    input  logic [IrWidth-1:0] irData,
    output instrClass_t        instrClass,
    output aluOp_t             aluOp
);

    opcode_t opcode;

    assign opcode = opcode_t'(irData[IrWidth-1 -: 5]);

    always_comb begin
        case (opcode)
            OpAdd, OpSub, OpAnd, OpOr, OpShr, OpShra, OpShl, OpRor, OpRol:
                instrClass = ClassAluReg;
            OpNeg, OpNot:         instrClass = ClassAluUnary;
            OpAddi, OpAndi, OpOri: instrClass = ClassAluImm;
            OpLdi:                instrClass = ClassLoadImm;
            OpLd:                 instrClass = ClassLoad;
            OpSt:                 instrClass = ClassStore;
            OpBr:                 instrClass = ClassBranch;
            OpJr:                 instrClass = ClassJumpReg;
            OpJal:                instrClass = ClassJumpLink;
            OpIn:                 instrClass = ClassInPort;
            OpOut:                instrClass = ClassOutPort;
            default:              instrClass = ClassNop;
        endcase
    end

    // Address and branch target sums all go through add
    always_comb begin
        case (opcode)
            OpAdd, OpAddi, OpLd, OpLdi, OpSt, OpBr: aluOp = AluAdd;
            OpSub:                                  aluOp = AluSub;
            OpAnd, OpAndi:                          aluOp = AluAnd;
            OpOr, OpOri:                            aluOp = AluOr;
            OpShr:                                  aluOp = AluShr;
            OpShra:                                 aluOp = AluShra;
            OpShl:                                  aluOp = AluShl;
            OpRor:                                  aluOp = AluRor;
            OpRol:                                  aluOp = AluRol;
            OpNeg:                                  aluOp = AluNeg;
            OpNot:                                  aluOp = AluNot;
            default:                                aluOp = AluNop;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/stepSequencer.sv
// Step sequencer for the control unit
// Walks fetch and execute steps, waits on memory steps and holds a step on stop
`default_nettype none

module stepSequencer
    import cpuCtrlPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        stop,
    input  instrClass_t instrClass,
    input  logic        memDone,
    output step_t       step,
    output logic        halted,
    output logic        memStart,
    output logic        memIsWrite,
    output logic        run
);

    // Steps that wait on a memory transfer
    function automatic logic isMemStep(step_t s, instrClass_t c);
        return (s == StepFetch2) ||
               (s == StepExec3 && c == ClassLoad) ||
               (s == StepExec4 && c == ClassStore);
    endfunction

    function automatic logic isWriteStep(step_t s, instrClass_t c);
        return (s == StepExec4) && (c == ClassStore);
    endfunction

    // Final execute step of each class
    function automatic logic isLastStep(step_t s, instrClass_t c);
        case (c)
            ClassAluReg, ClassAluUnary, ClassAluImm, ClassLoadImm:
                return s == StepExec2;
            ClassLoad, ClassStore:
                return s == StepExec4;
            ClassBranch:
                return s == StepExec3;
            default:
                return s == StepExec0;
        endcase
    endfunction

    function automatic step_t stepAfter(step_t s, instrClass_t c);
        if (isLastStep(s, c)) begin
            return StepFetch0;
        end
        case (s)
            StepStartup: return StepFetch0;
            StepFetch0:  return StepFetch1;
            StepFetch1:  return StepFetch2;
            StepFetch2:  return StepFetch3;
            StepFetch3:  return StepExec0;
            StepExec0:   return StepExec1;
            StepExec1:   return StepExec2;
            StepExec2:   return StepExec3;
            StepExec3:   return StepExec4;
            default:     return StepFetch0;
        endcase
    endfunction

    step_t nextStep;
    step_t enterStep;
    logic  boundary;
    logic  entering;
    logic  enterMem;

    assign nextStep = stepAfter(step, instrClass);

    // A memory step ends only with the closing handshake phase
    assign boundary = isMemStep(step, instrClass) ? memDone : 1'b1;

    // Step that starts running on the coming edge, either a fresh one or a resumed one
    assign enterStep = halted ? step : nextStep;
    assign entering  = halted ? !stop : (boundary && !stop);
    assign enterMem  = entering && isMemStep(enterStep, instrClass);

    assign run = !halted && (step != StepStartup);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step       <= StepStartup;
            halted     <= 1'b0;
            memStart   <= 1'b0;
            memIsWrite <= 1'b0;
        end else begin
            memStart <= enterMem;
            if (enterMem) begin
                memIsWrite <= isWriteStep(enterStep, instrClass);
            end

            if (halted) begin
                // Held step runs again once stop drops
                if (!stop) begin
                    halted <= 1'b0;
                end
            end else if (boundary) begin
                step <= nextStep;
                if (stop) begin
                    halted <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/memPort.sv
// Memory port master
// Runs one four-phase req/ack read or write per start pulse
`default_nettype none

module memPort (
    input  logic clk,
    input  logic reset,
    input  logic memStart,
    input  logic memIsWrite,
    input  logic memAck,
    output logic memReq,
    output logic memWrite,
    output logic dataPhase,
    output logic memDone
);

    typedef enum logic [1:0] {
        PortIdle,
        PortRequest,
        PortRelease
    } portState_t;

    portState_t state;

    assign memReq = (state == PortRequest);

    // First cycle with ack high while requesting
    assign dataPhase = (state == PortRequest) && memAck;

    // Ack seen low again after the request fell
    assign memDone = (state == PortRelease) && !memAck;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= PortIdle;
            memWrite <= 1'b0;
        end else begin
            case (state)
                PortIdle: begin
                    if (memStart) begin
                        state    <= PortRequest;
                        memWrite <= memIsWrite;
                    end
                end
                PortRequest: begin
                    if (memAck) begin
                        state <= PortRelease;
                    end
                end
                PortRelease: begin
                    if (!memAck) begin
                        state    <= PortIdle;
                        memWrite <= 1'b0;
                    end
                end
                default: state <= PortIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/controlWordGen.sv
// Control word generator
// Combinational table from step and instruction class to datapath enables
`default_nettype none

module controlWordGen
    import cpuCtrlPkg::*;
(
    input  step_t       step,
    input  instrClass_t instrClass,
    input  aluOp_t      aluOp,
    input  logic        halted,
    input  logic        dataPhase,
    output ctrlWord_t   ctrlWord
);

    always_comb begin
        ctrlWord       = '0;
        ctrlWord.aluOp = AluNop;

        // Startup and halted cycles keep every enable low
        if (!halted) begin
            case (step)
                StepFetch0: begin
                    ctrlWord.pcOut = 1'b1;
                    ctrlWord.marIn = 1'b1;
                    ctrlWord.incPc = 1'b1;
                    ctrlWord.zIn   = 1'b1;
                end
                StepFetch1: begin
                    ctrlWord.zLowOut = 1'b1;
                    ctrlWord.pcIn    = 1'b1;
                end
                StepFetch2: ctrlWord.mdrIn = dataPhase;
                StepFetch3: begin
                    ctrlWord.mdrOut = 1'b1;
                    ctrlWord.irIn   = 1'b1;
                end
                StepExec0: begin
                    case (instrClass)
                        ClassAluReg, ClassAluUnary, ClassAluImm: begin
                            ctrlWord.grb = 1'b1;
                            ctrlWord.yIn = 1'b1;
                        end
                        ClassLoadImm, ClassLoad, ClassStore: begin
                            ctrlWord.grb   = 1'b1;
                            ctrlWord.baOut = 1'b1;
                            ctrlWord.yIn   = 1'b1;
                        end
                        ClassBranch: ctrlWord = '{gra: 1'b1, rOut: 1'b1, connIn: 1'b1,
                                                  aluOp: AluNop, default: 1'b0};
                        ClassJumpReg: ctrlWord = '{gra: 1'b1, rOut: 1'b1, pcIn: 1'b1,
                                                   aluOp: AluNop, default: 1'b0};
                        ClassJumpLink: ctrlWord = '{gra: 1'b1, rIn: 1'b1, pcOut: 1'b1,
                                                    aluOp: AluNop, default: 1'b0};
                        ClassInPort: ctrlWord = '{inPortOut: 1'b1, gra: 1'b1, rIn: 1'b1,
                                                  aluOp: AluNop, default: 1'b0};
                        ClassOutPort: ctrlWord = '{outPortIn: 1'b1, gra: 1'b1, rOut: 1'b1,
                                                   aluOp: AluNop, default: 1'b0};
                        default: ;
                    endcase
                end
                StepExec1: begin
                    case (instrClass)
                        ClassAluReg: begin
                            ctrlWord.grc   = 1'b1;
                            ctrlWord.rOut  = 1'b1;
                            ctrlWord.zIn   = 1'b1;
                            ctrlWord.aluOp = aluOp;
                        end
                        ClassAluUnary: begin
                            ctrlWord.zIn   = 1'b1;
                            ctrlWord.aluOp = aluOp;
                        end
                        ClassAluImm, ClassLoadImm, ClassLoad, ClassStore: begin
                            ctrlWord.cOut  = 1'b1;
                            ctrlWord.zIn   = 1'b1;
                            ctrlWord.aluOp = aluOp;
                        end
                        ClassBranch: begin
                            ctrlWord.pcOut = 1'b1;
                            ctrlWord.yIn   = 1'b1;
                        end
                        default: ;
                    endcase
                end
                StepExec2: begin
                    case (instrClass)
                        // Result writeback from Z low
                        ClassAluReg, ClassAluUnary, ClassAluImm, ClassLoadImm: begin
                            ctrlWord.zLowOut = 1'b1;
                            ctrlWord.gra     = 1'b1;
                            ctrlWord.rIn     = 1'b1;
                        end
                        ClassLoad, ClassStore: begin
                            ctrlWord.zLowOut = 1'b1;
                            ctrlWord.marIn   = 1'b1;
                        end
                        ClassBranch: begin
                            ctrlWord.cOut  = 1'b1;
                            ctrlWord.zIn   = 1'b1;
                            ctrlWord.aluOp = aluOp;
                        end
                        default: ;
                    endcase
                end
                StepExec3: begin
                    case (instrClass)
                        ClassLoad: ctrlWord.mdrIn = dataPhase;
                        ClassStore: begin
                            ctrlWord.gra   = 1'b1;
                            ctrlWord.rOut  = 1'b1;
                            ctrlWord.mdrIn = 1'b1;
                        end
                        ClassBranch: begin
                            ctrlWord.zLowOut = 1'b1;
                            ctrlWord.pcIn    = 1'b1;
                        end
                        default: ;
                    endcase
                end
                StepExec4: begin
                    // Store write step drives nothing on the datapath
                    if (instrClass == ClassLoad) begin
                        ctrlWord.mdrOut = 1'b1;
                        ctrlWord.gra    = 1'b1;
                        ctrlWord.rIn    = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/ctrlUnit.sv
// Hardwired control unit top level
// Decoder, step sequencer, memory port and control word table
`default_nettype none

module ctrlUnit
    import cpuCtrlPkg::*;
#(
    parameter int IrWidth = 32
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               stop,
    input  logic [IrWidth-1:0] irData,
    input  logic               memAck,
    output ctrlWord_t          ctrlWord,
    output logic               memReq,
    output logic               memWrite,
    output logic               run
);

    instrClass_t instrClass;
    aluOp_t      aluOp;
    step_t       step;
    logic        halted;
    logic        memStart;
    logic        memIsWrite;
    logic        dataPhase;
    logic        memDone;

    opcodeDecoder #(
        .IrWidth(IrWidth)
    ) opcodeDecoder_inst (
        .irData    (irData),
        .instrClass(instrClass),
        .aluOp     (aluOp)
    );

    stepSequencer stepSequencer_inst (
        .clk       (clk),
        .reset     (reset),
        .stop      (stop),
        .instrClass(instrClass),
        .memDone   (memDone),
        .step      (step),
        .halted    (halted),
        .memStart  (memStart),
        .memIsWrite(memIsWrite),
        .run       (run)
    );

    memPort memPort_inst (
        .clk       (clk),
        .reset     (reset),
        .memStart  (memStart),
        .memIsWrite(memIsWrite),
        .memAck    (memAck),
        .memReq    (memReq),
        .memWrite  (memWrite),
        .dataPhase (dataPhase),
        .memDone   (memDone)
    );

    controlWordGen controlWordGen_inst (
        .step      (step),
        .instrClass(instrClass),
        .aluOp     (aluOp),
        .halted    (halted),
        .dataPhase (dataPhase),
        .ctrlWord  (ctrlWord)
    );

endmodule

`default_nettype wire

// File: tb/ctrlUnit_assertions.sv
// Handshake and halt checks for the control unit
// Bound to the top level of the control unit
`default_nettype none

module ctrlUnit_assertions
    import cpuCtrlPkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      memReq,
    input logic      memAck,
    input logic      memWrite,
    input logic      run,
    input ctrlWord_t ctrlWord
);

    // Request drops only after the memory acknowledged it
    reqHeldUntilAck: assert property (@(posedge clk) disable iff (reset)
        $fell(memReq) |-> $past(memAck))
        else $error("memReq fell before memAck was seen high");

    // Direction fixed for the whole request phase
    writeStableInRequest: assert property (@(posedge clk) disable iff (reset)
        memReq && $past(memReq) |-> $stable(memWrite))
        else $error("memWrite changed while memReq was high");

    idleWhenNotRunning: assert property (@(posedge clk) disable iff (reset)
        !run |-> ctrlWord == '0)
        else $error("ctrlWord not zero while run is low");

endmodule

bind ctrlUnit ctrlUnit_assertions ctrlUnit_assertions_inst (
    .clk     (clk),
    .reset   (reset),
    .memReq  (memReq),
    .memAck  (memAck),
    .memWrite(memWrite),
    .run     (run),
    .ctrlWord(ctrlWord)
);

`default_nettype wire

// File: tb/ctrlUnitTb.sv
// Testbench for the hardwired control unit
// Directed instruction sequences against a memory responder with random ack delays
`default_nettype none

module ctrlUnitTb
    import cpuCtrlPkg::*;
();

    localparam int ClkPeriod    = 40;
    localparam int ResetCycles  = 10;
    localparam int NumTests     = 6;
    localparam int MemWaitLimit = 20;
    localparam int IrWidth      = 32;
    localparam logic [31:0] Seed = 32'h75bee307;

    // Register and constant fields below the opcode, not used by the control unit
    localparam logic [IrWidth-6:0] RegFields = 27'h0a5_c3e1;

    localparam ctrlWord_t IdleWord   = '{aluOp: AluNop, default: 1'b0};
    localparam ctrlWord_t Fetch0Word =
        '{pcOut: 1'b1, marIn: 1'b1, incPc: 1'b1, zIn: 1'b1, aluOp: AluNop, default: 1'b0};
    localparam ctrlWord_t Fetch1Word = '{zLowOut: 1'b1, pcIn: 1'b1, aluOp: AluNop, default: 1'b0};
    localparam ctrlWord_t Fetch3Word = '{mdrOut: 1'b1, irIn: 1'b1, aluOp: AluNop, default: 1'b0};
    localparam ctrlWord_t OperandWord = '{grb: 1'b1, yIn: 1'b1, aluOp: AluNop, default: 1'b0};
    localparam ctrlWord_t BaseWord =
        '{grb: 1'b1, baOut: 1'b1, yIn: 1'b1, aluOp: AluNop, default: 1'b0};
    localparam ctrlWord_t ConstAddWord = '{cOut: 1'b1, zIn: 1'b1, aluOp: AluAdd, default: 1'b0};
    localparam ctrlWord_t WritebackWord =
        '{zLowOut: 1'b1, gra: 1'b1, rIn: 1'b1, aluOp: AluNop, default: 1'b0};
    localparam ctrlWord_t AddrWord = '{zLowOut: 1'b1, marIn: 1'b1, aluOp: AluNop, default: 1'b0};

    logic               clk;
    logic               reset;
    logic               stop;
    logic [IrWidth-1:0] irData;
    logic               memAck;
    ctrlWord_t          ctrlWord;
    logic               memReq;
    logic               memWrite;
    logic               run;

    // Input values applied at the next falling edge
    logic               resetNext;
    logic               stopNext;
    logic [IrWidth-1:0] irNext;
    ctrlWord_t          execWords[$];

    ctrlUnit #(
        .IrWidth(IrWidth)
    ) ctrlUnit_inst (
        .clk     (clk),
        .reset   (reset),
        .stop    (stop),
        .irData  (irData),
        .memAck  (memAck),
        .ctrlWord(ctrlWord),
        .memReq  (memReq),
        .memWrite(memWrite),
        .run     (run)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Memory side of the four-phase handshake
    initial begin : memResponder
        int unsigned delay;
        memAck = 1'b0;
        void'($urandom(Seed));
        forever begin
            @(negedge clk);
            if (memReq && !memAck) begin
                delay = $urandom % 6;
                repeat (delay) @(negedge clk);
                memAck = 1'b1;
                do begin
                    @(negedge clk);
                end while (memReq);
                delay = $urandom % 6;
                repeat (delay) @(negedge clk);
                memAck = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(NumTests * 200 * ClkPeriod);
        failNow("Watchdog expired before the tests finished");
    end

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic checkCtrlWord(input string name, input ctrlWord_t expected,
                                 input ctrlWord_t actual);
        if (actual !== expected) begin
            failNow($sformatf("[FAIL] %s: ctrlWord expected %h, actual %h",
                              name, expected, actual));
        end
    endtask

    task automatic checkBit(input string name, input string signal, input logic expected,
                            input logic actual);
        if (actual !== expected) begin
            failNow($sformatf("[FAIL] %s: %s expected %b, actual %b",
                              name, signal, expected, actual));
        end
    endtask

    task automatic checkAluOp(input string name, input aluOp_t expected, input aluOp_t actual);
        if (actual !== expected) begin
            failNow($sformatf("[FAIL] %s: aluOp expected %s (%0d), actual %s (%0d)",
                              name, expected.name(), expected, actual.name(), actual));
        end
    endtask

    // Falling edge drive, then settle before sampling
    task automatic advanceCycle();
        @(negedge clk);
        reset  = resetNext;
        stop   = stopNext;
        irData = irNext;
        #(ClkPeriod / 4);
    endtask

    task automatic expectStep(input string name, input ctrlWord_t expected);
        checkCtrlWord(name, expected, ctrlWord);
        checkBit(name, "run", 1'b1, run);
        checkBit(name, "memReq", 1'b0, memReq);
    endtask

    task automatic expectHalted(input string name);
        checkCtrlWord(name, IdleWord, ctrlWord);
        checkBit(name, "run", 1'b0, run);
        checkBit(name, "memReq", 1'b0, memReq);
    endtask

    // Entered on the first halted cycle, left on the resumed step
    task automatic holdAndResume(input string name);
        expectHalted({name, " halted"});
        advanceCycle();
        expectHalted({name, " halted"});
        stopNext = 1'b0;
        advanceCycle();
        expectHalted({name, " stop released"});
        advanceCycle();
    endtask

    // Entered on the first cycle of a memory step, left on its memDone cycle
    task automatic memoryTransfer(input string name, input logic isWrite);
        int        waited;
        ctrlWord_t dataWord;
        expectStep({name, " start"}, IdleWord);
        advanceCycle();
        waited = 0;
        while (!memAck) begin
            checkBit({name, " request"}, "memReq", 1'b1, memReq);
            checkBit({name, " request"}, "memWrite", isWrite, memWrite);
            checkBit({name, " request"}, "run", 1'b1, run);
            checkCtrlWord({name, " request"}, IdleWord, ctrlWord);
            advanceCycle();
            waited++;
            if (waited > MemWaitLimit) begin
                failNow($sformatf("%s: memory ack never rose", name));
            end
        end
        dataWord       = IdleWord;
        dataWord.mdrIn = !isWrite;
        checkBit({name, " data"}, "memReq", 1'b1, memReq);
        checkBit({name, " data"}, "memWrite", isWrite, memWrite);
        checkBit({name, " data"}, "run", 1'b1, run);
        checkCtrlWord({name, " data"}, dataWord, ctrlWord);
        advanceCycle();
        waited = 0;
        while (memAck) begin
            expectStep({name, " release"}, IdleWord);
            advanceCycle();
            waited++;
            if (waited > MemWaitLimit) begin
                failNow($sformatf("%s: memory ack never fell", name));
            end
        end
        expectStep({name, " done"}, IdleWord);
    endtask

    // From the fetch0 cycle to the fetch3 cycle
    task automatic fetchPhase(input string name, input logic [4:0] op, input logic holdInFetch);
        expectStep({name, " fetch0"}, Fetch0Word);
        advanceCycle();
        expectStep({name, " fetch1"}, Fetch1Word);
        advanceCycle();
        if (holdInFetch) begin
            stopNext = 1'b1;
        end
        memoryTransfer({name, " fetch2"}, 1'b0);
        irNext = {op, RegFields};
        advanceCycle();
        if (holdInFetch) begin
            holdAndResume({name, " fetch3"});
        end
        expectStep({name, " fetch3"}, Fetch3Word);
    endtask

    task automatic runInstr(input string name, input logic [4:0] op, input int memStep);
        string stepName;
        fetchPhase(name, op, 1'b0);
        for (int i = 0; i < execWords.size(); i++) begin
            stepName = $sformatf("%s exec%0d", name, i);
            advanceCycle();
            if (i == memStep) begin
                memoryTransfer(stepName, op == OpSt);
            end else begin
                checkAluOp(stepName, execWords[i].aluOp, ctrlWord.aluOp);
                expectStep(stepName, execWords[i]);
            end
        end
        advanceCycle();
    endtask

    function automatic aluOp_t expectedAluOp(input opcode_t op);
        case (op)
            OpAdd, OpAddi: return AluAdd;
            OpSub:         return AluSub;
            OpAnd, OpAndi: return AluAnd;
            OpOr, OpOri:   return AluOr;
            OpShr:         return AluShr;
            OpShra:        return AluShra;
            OpShl:         return AluShl;
            OpRor:         return AluRor;
            OpRol:         return AluRol;
            OpNeg:         return AluNeg;
            OpNot:         return AluNot;
            default:       return AluNop;
        endcase
    endfunction

    task automatic resetTest();
        repeat (ResetCycles) begin
            advanceCycle();
            checkCtrlWord("reset", IdleWord, ctrlWord);
            checkBit("reset", "run", 1'b0, run);
            checkBit("reset", "memReq", 1'b0, memReq);
            checkBit("reset", "memWrite", 1'b0, memWrite);
        end
        resetNext = 1'b0;
        advanceCycle();
        checkCtrlWord("startup", IdleWord, ctrlWord);
        checkBit("startup", "run", 1'b0, run);
        advanceCycle();
    endtask

    task automatic aluRegTests();
        opcode_t   ops[11] = '{OpAdd, OpSub, OpAnd, OpOr, OpShl, OpShr, OpShra,
                               OpRol, OpRor, OpNeg, OpNot};
        ctrlWord_t opWord;
        foreach (ops[i]) begin
            opWord       = IdleWord;
            opWord.zIn   = 1'b1;
            opWord.aluOp = expectedAluOp(ops[i]);
            // Unary ops take no second register operand
            if (ops[i] != OpNeg && ops[i] != OpNot) begin
                opWord.grc  = 1'b1;
                opWord.rOut = 1'b1;
            end
            execWords = {OperandWord, opWord, WritebackWord};
            runInstr(ops[i].name(), ops[i], -1);
        end
    endtask

    task automatic immTests();
        opcode_t   ops[3] = '{OpAddi, OpAndi, OpOri};
        ctrlWord_t opWord;
        foreach (ops[i]) begin
            opWord       = ConstAddWord;
            opWord.aluOp = expectedAluOp(ops[i]);
            execWords    = {OperandWord, opWord, WritebackWord};
            runInstr(ops[i].name(), ops[i], -1);
        end
        execWords = {BaseWord, ConstAddWord, WritebackWord};
        runInstr("ldi", OpLdi, -1);
    endtask

    task automatic memTests();
        ctrlWord_t loadWord  = '{mdrOut: 1'b1, gra: 1'b1, rIn: 1'b1, aluOp: AluNop, default: 1'b0};
        ctrlWord_t storeWord = '{gra: 1'b1, rOut: 1'b1, mdrIn: 1'b1, aluOp: AluNop, default: 1'b0};
        repeat (3) begin
            execWords = {BaseWord, ConstAddWord, AddrWord, IdleWord, loadWord};
            runInstr("ld", OpLd, 3);
            execWords = {BaseWord, ConstAddWord, AddrWord, storeWord, IdleWord};
            runInstr("st", OpSt, 4);
        end
    endtask

    task automatic controlFlowTests();
        ctrlWord_t brCond  = '{gra: 1'b1, rOut: 1'b1, connIn: 1'b1, aluOp: AluNop, default: 1'b0};
        ctrlWord_t brPc    = '{pcOut: 1'b1, yIn: 1'b1, aluOp: AluNop, default: 1'b0};
        ctrlWord_t jrWord  = '{gra: 1'b1, rOut: 1'b1, pcIn: 1'b1, aluOp: AluNop, default: 1'b0};
        ctrlWord_t jalWord = '{gra: 1'b1, rIn: 1'b1, pcOut: 1'b1, aluOp: AluNop, default: 1'b0};
        ctrlWord_t inWord  =
            '{inPortOut: 1'b1, gra: 1'b1, rIn: 1'b1, aluOp: AluNop, default: 1'b0};
        ctrlWord_t outWord =
            '{outPortIn: 1'b1, gra: 1'b1, rOut: 1'b1, aluOp: AluNop, default: 1'b0};
        execWords = {brCond, brPc, ConstAddWord, Fetch1Word};
        runInstr("br", OpBr, -1);
        execWords = {jrWord};
        runInstr("jr", OpJr, -1);
        execWords = {jalWord};
        runInstr("jal", OpJal, -1);
        execWords = {inWord};
        runInstr("in", OpIn, -1);
        execWords = {outWord};
        runInstr("out", OpOut, -1);
        execWords = {IdleWord};
        runInstr("unknown opcode", 5'd30, -1);
    endtask

    task automatic stopTests();
        ctrlWord_t subWord = '{grc: 1'b1, rOut: 1'b1, zIn: 1'b1, aluOp: AluSub, default: 1'b0};
        ctrlWord_t jrWord  = '{gra: 1'b1, rOut: 1'b1, pcIn: 1'b1, aluOp: AluNop, default: 1'b0};
        fetchPhase("stop sub", OpSub, 1'b0);
        stopNext = 1'b1;
        advanceCycle();
        expectStep("stop sub exec0", OperandWord);
        advanceCycle();
        holdAndResume("stop sub exec1");
        expectStep("stop sub exec1", subWord);
        advanceCycle();
        expectStep("stop sub exec2", WritebackWord);
        advanceCycle();
        // Stop raised inside the fetch read waits for the transfer to close
        fetchPhase("stop in fetch", OpJr, 1'b1);
        advanceCycle();
        expectStep("stop in fetch exec0", jrWord);
        advanceCycle();
    endtask

    initial begin : stimulus
        reset     = 1'b1;
        stop      = 1'b0;
        irData    = '0;
        resetNext = 1'b1;
        stopNext  = 1'b0;
        irNext    = '0;
        resetTest();
        aluRegTests();
        immTests();
        memTests();
        controlFlowTests();
        stopTests();
        expectStep("final fetch0", Fetch0Word);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/cpuCtrlPkg.sv
rtl/opcodeDecoder.sv
rtl/stepSequencer.sv
rtl/memPort.sv
rtl/controlWordGen.sv
rtl/ctrlUnit.sv
tb/ctrlUnit_assertions.sv
tb/ctrlUnitTb.sv

// File: Bender.yml
package:
  name: cpu_ctrl_unit

sources:
  # Control unit RTL, package first
  - rtl/cpuCtrlPkg.sv
  - rtl/opcodeDecoder.sv
  - rtl/stepSequencer.sv
  - rtl/memPort.sv
  - rtl/controlWordGen.sv
  - rtl/ctrlUnit.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - tb/ctrlUnit_assertions.sv
      - tb/ctrlUnitTb.sv
